// ==== Makefile ====
TOP := tb_core_mul_div_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== hw/core_mul_div_ctrl.sv ====
`timescale 1ns/100ps

module core_mul_div_ctrl
(
  input  logic               i_mul_div_ctrl_clk,
  input  logic               i_mul_div_ctrl_rstn,
  input  mul_div_pkg::xlen_t i_mul_div_ctrl_src_a,
  input  mul_div_pkg::xlen_t i_mul_div_ctrl_src_b,
  input  mul_div_pkg::op_t   i_mul_div_ctrl_op,
  input  logic               i_mul_div_ctrl_isword,
  input  logic               i_mul_div_ctrl_en,
  input  logic               i_mul_div_ctrl_mul_dn,
  input  logic               i_mul_div_ctrl_div_dn,
  output logic               o_mul_div_ctrl_mul_start,
  output logic               o_mul_div_ctrl_div_start,
  output logic               o_mul_div_ctrl_busy,
  output logic               o_mul_div_ctrl_done,
  output mul_div_pkg::xlen_t o_mul_div_ctrl_out_fast,
  output logic               o_mul_div_ctrl_div_by_zero,
  output logic               o_mul_div_ctrl_overflow,
  output logic               o_mul_div_ctrl_out_sel
);

mul_div_pkg::operand_class_t class_a;
mul_div_pkg::operand_class_t class_b;
logic                        fast_hit;
mul_div_pkg::xlen_t          fast_value;
logic                        div_by_zero;
logic                        overflow;

mul_div_operand_class u_operand_class
(
  .i_src_a   (i_mul_div_ctrl_src_a),
  .i_src_b   (i_mul_div_ctrl_src_b),
  .i_isword  (i_mul_div_ctrl_isword),
  .o_class_a (class_a),
  .o_class_b (class_b)
);

mul_div_fast_path u_fast_path
(
  .i_src_a       (i_mul_div_ctrl_src_a),
  .i_src_b       (i_mul_div_ctrl_src_b),
  .i_op          (i_mul_div_ctrl_op),
  .i_isword      (i_mul_div_ctrl_isword),
  .i_class_a     (class_a),
  .i_class_b     (class_b),
  .o_fast_hit    (fast_hit),
  .o_fast_value  (fast_value),
  .o_div_by_zero (div_by_zero),
  .o_overflow    (overflow)
);

mul_div_sequencer u_sequencer
(
  .i_mul_div_ctrl_clk  (i_mul_div_ctrl_clk),
  .i_mul_div_ctrl_rstn (i_mul_div_ctrl_rstn),
  .i_en                (i_mul_div_ctrl_en),
  .i_op                (i_mul_div_ctrl_op),
  .i_fast_hit          (fast_hit),
  .i_fast_value        (fast_value),
  .i_div_by_zero       (div_by_zero),
  .i_overflow          (overflow),
  .i_mul_dn            (i_mul_div_ctrl_mul_dn),
  .i_div_dn            (i_mul_div_ctrl_div_dn),
  .o_mul_start         (o_mul_div_ctrl_mul_start),
  .o_div_start         (o_mul_div_ctrl_div_start),
  .o_busy              (o_mul_div_ctrl_busy),
  .o_done              (o_mul_div_ctrl_done),
  .o_out_fast          (o_mul_div_ctrl_out_fast),
  .o_div_by_zero       (o_mul_div_ctrl_div_by_zero),
  .o_overflow          (o_mul_div_ctrl_overflow),
  .o_out_sel           (o_mul_div_ctrl_out_sel)
);

endmodule

// ==== hw/mul_div_fast_path.sv ====
`timescale 1ns/100ps

module mul_div_fast_path
(
  input  mul_div_pkg::xlen_t          i_src_a,
  input  mul_div_pkg::xlen_t          i_src_b,
  input  mul_div_pkg::op_t            i_op,
  input  logic                        i_isword,
  input  mul_div_pkg::operand_class_t i_class_a,
  input  mul_div_pkg::operand_class_t i_class_b,
  output logic                        o_fast_hit,
  output mul_div_pkg::xlen_t          o_fast_value,
  output logic                        o_div_by_zero,
  output logic                        o_overflow
);

logic               is_div;
logic               is_rem;
logic               is_mul;
logic               signed_div;
logic               rule_ovf;
logic               rule_b_zero;
logic               rule_a_zero;
logic               rule_b_one;
logic               rule_b_m1;
logic               rule_a_one;
mul_div_pkg::xlen_t raw;
mul_div_pkg::word_t raw_lo;

assign is_div     = i_op[2];
assign is_rem     = i_op[2] & i_op[1];
assign is_mul     = (i_op == mul_div_pkg::MUL); // MULH* always go to the multiplier
assign signed_div = (i_op == mul_div_pkg::DIV) || (i_op == mul_div_pkg::REM);

// Rule conditions before priority
assign rule_ovf    = signed_div && (i_class_a == mul_div_pkg::CLS_MIN_NEG) &&
                     (i_class_b == mul_div_pkg::CLS_MINUS_ONE);
assign rule_b_zero = (i_class_b == mul_div_pkg::CLS_ZERO);
assign rule_a_zero = (i_class_a == mul_div_pkg::CLS_ZERO);
assign rule_b_one  = (i_class_b == mul_div_pkg::CLS_ONE) && (is_mul || is_div);
assign rule_b_m1   = (i_class_b == mul_div_pkg::CLS_MINUS_ONE) &&
                     (is_mul || signed_div);
assign rule_a_one  = (i_class_a == mul_div_pkg::CLS_ONE) && (is_mul || is_div);

always_comb
  begin: fast_rule_proc
    raw           = '0;
    o_fast_hit    = 1'b1;
    o_div_by_zero = 1'b0;
    o_overflow    = 1'b0;
    if (rule_ovf)
      begin
        raw        = is_rem ? '0 : i_src_a;
        o_overflow = 1'b1;
      end
    else if (rule_b_zero)
      begin
        if (is_div)
          raw = is_rem ? i_src_a : '1;
        o_div_by_zero = is_div;
      end
    else if (rule_a_zero)
      begin
        raw = '0;
      end
    else if (rule_b_one)
      begin
        raw = is_rem ? '0 : i_src_a;
      end
    else if (rule_b_m1)
      begin
        raw = is_rem ? '0 : -i_src_a; // Low W bits of -A are right in word mode too
      end
    else if (rule_a_one)
      begin
        if (is_mul)
          raw = i_src_b;
        else
          raw = is_rem ? mul_div_pkg::xlen_t'(1) : '0;
      end
    else
      begin
        o_fast_hit = 1'b0;
      end
  end

assign raw_lo = raw[mul_div_pkg::WLEN-1:0];

// Word results are sign-extended from bit 31
assign o_fast_value = i_isword ?
                      {{(mul_div_pkg::XLEN-mul_div_pkg::WLEN){raw_lo[mul_div_pkg::WLEN-1]}},
                       raw_lo} :
                      raw;

endmodule

// ==== hw/mul_div_operand_class.sv ====
`timescale 1ns/100ps

module mul_div_operand_class
(
  input  mul_div_pkg::xlen_t          i_src_a,
  input  mul_div_pkg::xlen_t          i_src_b,
  input  logic                        i_isword,
  output mul_div_pkg::operand_class_t o_class_a,
  output mul_div_pkg::operand_class_t o_class_b
);

localparam mul_div_pkg::xlen_t XLEN_MIN = {1'b1, {(mul_div_pkg::XLEN-1){1'b0}}};
localparam mul_div_pkg::word_t WORD_MIN = {1'b1, {(mul_div_pkg::WLEN-1){1'b0}}};

function automatic mul_div_pkg::operand_class_t classify
(
  input mul_div_pkg::xlen_t value,
  input logic               isword,
  input logic               check_min
);
  mul_div_pkg::word_t lo;
  logic               zero;
  logic               one;
  logic               ones;
  logic               min_neg;
  lo      = value[mul_div_pkg::WLEN-1:0];
  zero    = isword ? (lo == '0) : (value == '0);
  one     = isword ? (lo == mul_div_pkg::word_t'(1)) : (value == mul_div_pkg::xlen_t'(1));
  ones    = isword ? (&lo) : (&value);
  min_neg = isword ? (lo == WORD_MIN) : (value == XLEN_MIN);
  if (zero)
    classify = mul_div_pkg::CLS_ZERO;
  else if (one)
    classify = mul_div_pkg::CLS_ONE;
  else if (ones)
    classify = mul_div_pkg::CLS_MINUS_ONE;
  else if (min_neg && check_min)
    classify = mul_div_pkg::CLS_MIN_NEG;
  else
    classify = mul_div_pkg::CLS_OTHER;
endfunction

always_comb
  begin: classify_proc
    o_class_a = classify(i_src_a, i_isword, 1'b1);
    o_class_b = classify(i_src_b, i_isword, 1'b0); // Divisor never needs MIN_NEG
  end

endmodule

// ==== hw/mul_div_pkg.sv ====
package mul_div_pkg;

localparam int XLEN = 64;
localparam int WLEN = 32; // Word mode, RV64 *W instructions

typedef logic [XLEN-1:0] xlen_t;
typedef logic [WLEN-1:0] word_t;

// Same encoding as funct3 of the M extension
typedef enum logic [2:0]
{
  MUL    = 3'd0,
  MULH   = 3'd1,
  MULHSU = 3'd2,
  MULHU  = 3'd3,
  DIV    = 3'd4,
  DIVU   = 3'd5,
  REM    = 3'd6,
  REMU   = 3'd7
} op_t;

typedef enum logic [2:0]
{
  CLS_OTHER,
  CLS_ZERO,
  CLS_ONE,
  CLS_MINUS_ONE,
  CLS_MIN_NEG // Only reported for the dividend
} operand_class_t;

typedef enum logic [1:0]
{
  ST_IDLE,
  ST_FAST,
  ST_MUL,
  ST_DIV
} ctrl_state_t;

endpackage

// ==== hw/mul_div_sequencer.sv ====
`timescale 1ns/100ps

module mul_div_sequencer
(
  input  logic               i_mul_div_ctrl_clk,
  input  logic               i_mul_div_ctrl_rstn,
  input  logic               i_en,
  input  mul_div_pkg::op_t   i_op,
  input  logic               i_fast_hit,
  input  mul_div_pkg::xlen_t i_fast_value,
  input  logic               i_div_by_zero,
  input  logic               i_overflow,
  input  logic               i_mul_dn,
  input  logic               i_div_dn,
  output logic               o_mul_start,
  output logic               o_div_start,
  output logic               o_busy,
  output logic               o_done,
  output mul_div_pkg::xlen_t o_out_fast,
  output logic               o_div_by_zero,
  output logic               o_overflow,
  output logic               o_out_sel
);

mul_div_pkg::ctrl_state_t state_q;
mul_div_pkg::ctrl_state_t state_d;
logic                     accept;
logic                     is_div;
logic                     in_fast;
mul_div_pkg::xlen_t       fast_value_q;
logic                     div_by_zero_q;
logic                     overflow_q;
logic                     out_sel_q;

assign accept  = (state_q == mul_div_pkg::ST_IDLE) && i_en; // en ignored when not idle
assign is_div  = i_op[2];
assign in_fast = (state_q == mul_div_pkg::ST_FAST);

always_comb
  begin: next_state_proc
    state_d = state_q;
    case (state_q)
      mul_div_pkg::ST_IDLE:
        begin
          if (accept && i_fast_hit)
            state_d = mul_div_pkg::ST_FAST;
          else if (accept)
            state_d = is_div ? mul_div_pkg::ST_DIV : mul_div_pkg::ST_MUL;
        end
      mul_div_pkg::ST_FAST:
        state_d = mul_div_pkg::ST_IDLE; // Done lasts a single cycle
      mul_div_pkg::ST_MUL:
        if (i_mul_dn)
          state_d = mul_div_pkg::ST_IDLE;
      mul_div_pkg::ST_DIV:
        if (i_div_dn)
          state_d = mul_div_pkg::ST_IDLE;
      default:
        state_d = mul_div_pkg::ST_IDLE;
    endcase
  end

always_ff @(posedge i_mul_div_ctrl_clk, negedge i_mul_div_ctrl_rstn)
  begin: ctrl_reg_proc
    if (!i_mul_div_ctrl_rstn)
      begin
        state_q       <= mul_div_pkg::ST_IDLE;
        div_by_zero_q <= 1'b0;
        overflow_q    <= 1'b0;
        out_sel_q     <= 1'b0;
      end
    else
      begin
        state_q <= state_d;
        if (accept)
          begin
            div_by_zero_q <= i_div_by_zero;
            overflow_q    <= i_overflow;
            out_sel_q     <= i_fast_hit; // Held until next acceptance
          end
      end
  end

always_ff @(posedge i_mul_div_ctrl_clk)
  begin: fast_value_proc
    if (accept)
      fast_value_q <= i_fast_value;
  end

assign o_mul_start   = accept && !i_fast_hit && !is_div;
assign o_div_start   = accept && !i_fast_hit && is_div;
assign o_busy        = (state_q != mul_div_pkg::ST_IDLE);
assign o_done        = in_fast ||
                       ((state_q == mul_div_pkg::ST_MUL) && i_mul_dn) ||
                       ((state_q == mul_div_pkg::ST_DIV) && i_div_dn);
assign o_out_fast    = in_fast ? fast_value_q : '0;
assign o_div_by_zero = in_fast && div_by_zero_q;
assign o_overflow    = in_fast && overflow_q;
assign o_out_sel     = out_sel_q;

// Each start strobe lands in the wait state of its own unit
a_mul_start_wait: assert property (@(posedge i_mul_div_ctrl_clk)
  disable iff (!i_mul_div_ctrl_rstn)
  o_mul_start |=> (state_q == mul_div_pkg::ST_MUL));

a_div_start_wait: assert property (@(posedge i_mul_div_ctrl_clk)
  disable iff (!i_mul_div_ctrl_rstn)
  o_div_start |=> (state_q == mul_div_pkg::ST_DIV));

a_done_to_idle: assert property (@(posedge i_mul_div_ctrl_clk) disable iff (!i_mul_div_ctrl_rstn)
  o_done |=> !o_busy);

// Multiplier must stay quiet while a divide is outstanding
a_no_mul_dn_in_div: assert property (@(posedge i_mul_div_ctrl_clk)
  disable iff (!i_mul_div_ctrl_rstn)
  (state_q == mul_div_pkg::ST_DIV) |-> !i_mul_dn);

endmodule

// ==== include/tb_mul_div_model.svh ====
`ifndef TB_MUL_DIV_MODEL_SVH
`define TB_MUL_DIV_MODEL_SVH

function automatic mul_div_pkg::xlen_t model_sext
(
  input mul_div_pkg::xlen_t value,
  input logic               isword
);
  mul_div_pkg::word_t lo;
  lo = value[mul_div_pkg::WLEN-1:0];
  model_sext = isword ? {{(mul_div_pkg::XLEN-mul_div_pkg::WLEN){lo[mul_div_pkg::WLEN-1]}}, lo} :
               value;
endfunction

// Expected fast hit, value and flags for one operation
function automatic void model_eval
(
  input  mul_div_pkg::op_t   op,
  input  mul_div_pkg::xlen_t src_a,
  input  mul_div_pkg::xlen_t src_b,
  input  logic               isword,
  output logic               hit,
  output mul_div_pkg::xlen_t value,
  output logic               div_by_zero,
  output logic               overflow
);
  mul_div_pkg::xlen_t a;
  mul_div_pkg::xlen_t b;
  mul_div_pkg::xlen_t min_neg;
  mul_div_pkg::xlen_t raw;
  logic               is_div;
  logic               is_rem;
  logic               is_mul;
  logic               sdiv;
  a           = model_sext(src_a, isword);
  b           = model_sext(src_b, isword);
  min_neg     = isword ? 64'hFFFF_FFFF_8000_0000 : 64'h8000_0000_0000_0000;
  is_div      = op[2];
  is_rem      = op[2] & op[1];
  is_mul      = (op == mul_div_pkg::MUL);
  sdiv        = (op == mul_div_pkg::DIV) || (op == mul_div_pkg::REM);
  hit         = 1'b1;
  raw         = '0;
  div_by_zero = 1'b0;
  overflow    = 1'b0;
  if (sdiv && a == min_neg && b == '1)
    begin
      raw      = is_rem ? '0 : a;
      overflow = 1'b1;
    end
  else if (b == '0)
    begin
      raw         = !is_div ? '0 : (is_rem ? a : '1);
      div_by_zero = is_div;
    end
  else if (a == '0)
    raw = '0;
  else if (b == 64'd1 && (is_mul || is_div))
    raw = is_rem ? '0 : a;
  else if (b == '1 && (is_mul || sdiv))
    raw = is_rem ? '0 : (~a + 64'd1);
  else if (a == 64'd1 && (is_mul || is_div))
    raw = is_mul ? b : (is_rem ? 64'd1 : '0);
  else
    hit = 1'b0;
  value = model_sext(raw, isword);
endfunction

`endif

// ==== sim/tb_core_mul_div_ctrl.sv ====
`timescale 1ns/100ps

module tb_core_mul_div_ctrl;

localparam int NUM_OPS    = 3000;
localparam int WAIT_LIMIT = 20; // Responder answers within 8 cycles

logic               clk;
logic               rstn;
mul_div_pkg::xlen_t src_a;
mul_div_pkg::xlen_t src_b;
mul_div_pkg::op_t   op;
logic               isword;
logic               en;
logic               mul_dn;
logic               div_dn;
logic               mul_start;
logic               div_start;
logic               busy;
logic               done;
mul_div_pkg::xlen_t out_fast;
logic               div_by_zero;
logic               overflow;
logic               out_sel;

logic [31:0]        lfsr_state;
int                 resp_delay; // Responder delay for the next start
int                 hit_count;
int                 miss_count;
int                 dbz_count;
int                 ovf_count;

`include "tb_mul_div_model.svh"

core_mul_div_ctrl uut
(
  .i_mul_div_ctrl_clk         (clk),
  .i_mul_div_ctrl_rstn        (rstn),
  .i_mul_div_ctrl_src_a       (src_a),
  .i_mul_div_ctrl_src_b       (src_b),
  .i_mul_div_ctrl_op          (op),
  .i_mul_div_ctrl_isword      (isword),
  .i_mul_div_ctrl_en          (en),
  .i_mul_div_ctrl_mul_dn      (mul_dn),
  .i_mul_div_ctrl_div_dn      (div_dn),
  .o_mul_div_ctrl_mul_start   (mul_start),
  .o_mul_div_ctrl_div_start   (div_start),
  .o_mul_div_ctrl_busy        (busy),
  .o_mul_div_ctrl_done        (done),
  .o_mul_div_ctrl_out_fast    (out_fast),
  .o_mul_div_ctrl_div_by_zero (div_by_zero),
  .o_mul_div_ctrl_overflow    (overflow),
  .o_mul_div_ctrl_out_sel     (out_sel)
);

initial
  begin: clock_gen
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  lfsr_next = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

task automatic draw_bits(input int count, output logic [63:0] bits);
  bits = '0;
  for (int i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      bits       = {bits[62:0], lfsr_state[0]};
    end
endtask

task automatic draw_operand(output mul_div_pkg::xlen_t value);
  logic [63:0] pick;
  logic [63:0] rnd;
  draw_bits(3, pick);
  case (pick[2:0])
    3'd0:    value = '0;
    3'd1:    value = 64'd1;
    3'd2:    value = '1;
    3'd3:    value = 64'h8000_0000_0000_0000;
    3'd4:    value = 64'h0000_0000_8000_0000; // Most negative in word mode only
    default:
      begin
        draw_bits(64, rnd);
        value = rnd;
      end
  endcase
  if (pick[2:0] < 3'd5)
    begin
      draw_bits(1, pick);
      if (pick[0])
        begin
          draw_bits(32, rnd);
          value[63:32] = rnd[31:0]; // Junk upper half keeps it special in word mode
        end
    end
endtask

task automatic halt_run;
  $display("TESTBENCH FAILED");
  $fatal(1, "Stopped at the first error");
endtask

task automatic check_value
(
  input string              name,
  input mul_div_pkg::xlen_t actual,
  input mul_div_pkg::xlen_t expected
);
  if (actual !== expected)
    begin
      $display("[FAIL] %s: got 0x%016h, expected 0x%016h", name, actual, expected);
      halt_run();
    end
endtask

task automatic check_flag(input string name, input logic actual, input logic expected);
  if (actual !== expected)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      halt_run();
    end
endtask

// Start strobes in the en cycle follow the divide bit of the op
task automatic check_op_path
(
  input mul_div_pkg::op_t op_chk,
  input logic             hit,
  input logic             mul_seen,
  input logic             div_seen
);
  logic exp_mul;
  logic exp_div;
  exp_mul = !hit && !op_chk[2];
  exp_div = !hit && op_chk[2];
  if (mul_seen !== exp_mul || div_seen !== exp_div)
    begin
      $display("[FAIL] o_mul_div_ctrl_mul_start/div_start for op 0x%h: got 0x%h/0x%h,",
               op_chk, mul_seen, div_seen);
      $display("[FAIL] expected 0x%h/0x%h", exp_mul, exp_div);
      halt_run();
    end
endtask

task automatic check_no_result;
  check_value("o_mul_div_ctrl_out_fast", out_fast, '0);
  check_flag("o_mul_div_ctrl_div_by_zero", div_by_zero, 1'b0);
  check_flag("o_mul_div_ctrl_overflow", overflow, 1'b0);
endtask

task automatic run_operation;
  mul_div_pkg::op_t   op_new;
  logic               word_new;
  mul_div_pkg::xlen_t a_new;
  mul_div_pkg::xlen_t b_new;
  logic               exp_hit;
  mul_div_pkg::xlen_t exp_value;
  logic               exp_dbz;
  logic               exp_ovf;
  logic               poke;
  logic [63:0]        bits;
  int                 wait_cycles;
  logic               finished;
  draw_bits(3, bits);
  op_new = mul_div_pkg::op_t'(bits[2:0]);
  draw_bits(1, bits);
  word_new = bits[0];
  draw_operand(a_new);
  draw_operand(b_new);
  draw_bits(3, bits);
  resp_delay = int'(bits[2:0]) + 1;
  draw_bits(1, bits);
  poke = bits[0];
  model_eval(op_new, a_new, b_new, word_new, exp_hit, exp_value, exp_dbz, exp_ovf);
  @(posedge clk);
  src_a  <= a_new;
  src_b  <= b_new;
  op     <= op_new;
  isword <= word_new;
  en     <= 1'b1;
  @(negedge clk);
  check_op_path(op_new, exp_hit, mul_start, div_start);
  check_flag("o_mul_div_ctrl_busy", busy, 1'b0);
  check_flag("o_mul_div_ctrl_done", done, 1'b0);
  check_no_result();
  @(posedge clk);
  en    <= 1'b0;
  src_a <= ~a_new; // Result was captured at acceptance
  if (exp_hit)
    begin
      hit_count = hit_count + 1;
      dbz_count = dbz_count + int'(exp_dbz);
      ovf_count = ovf_count + int'(exp_ovf);
      @(negedge clk);
      check_flag("o_mul_div_ctrl_done", done, 1'b1);
      check_flag("o_mul_div_ctrl_busy", busy, 1'b1);
      check_flag("o_mul_div_ctrl_mul_start", mul_start, 1'b0);
      check_flag("o_mul_div_ctrl_div_start", div_start, 1'b0);
      check_value("o_mul_div_ctrl_out_fast", out_fast, exp_value);
      check_flag("o_mul_div_ctrl_div_by_zero", div_by_zero, exp_dbz);
      check_flag("o_mul_div_ctrl_overflow", overflow, exp_ovf);
      check_flag("o_mul_div_ctrl_out_sel", out_sel, 1'b1);
      @(negedge clk);
      check_flag("o_mul_div_ctrl_done", done, 1'b0);
      check_flag("o_mul_div_ctrl_busy", busy, 1'b0);
      check_flag("o_mul_div_ctrl_out_sel", out_sel, 1'b1);
      check_no_result();
    end
  else
    begin
      miss_count  = miss_count + 1;
      wait_cycles = 0;
      finished    = 1'b0;
      while (!finished)
        begin
          @(negedge clk);
          wait_cycles = wait_cycles + 1;
          check_flag("o_mul_div_ctrl_mul_start", mul_start, 1'b0);
          check_flag("o_mul_div_ctrl_div_start", div_start, 1'b0);
          check_flag("o_mul_div_ctrl_busy", busy, 1'b1);
          check_flag("o_mul_div_ctrl_out_sel", out_sel, 1'b0);
          check_no_result();
          if (done)
            finished = 1'b1;
          else if (wait_cycles >= WAIT_LIMIT)
            begin
              $display("No done from the DUT within %0d cycles of a start", WAIT_LIMIT);
              halt_run();
            end
          else
            begin
              @(posedge clk);
              en    <= poke && (wait_cycles == 1); // Stray en while busy
              src_b <= '0;                         // Would be a fast hit if taken
            end
        end
      if (wait_cycles != resp_delay)
        begin
          $display("Done came %0d cycles after the start but the unit answered after %0d",
                   wait_cycles, resp_delay);
          halt_run();
        end
    end
endtask

initial
  begin: unit_responder
    logic answer_div;
    int   delay;
    mul_dn <= 1'b0;
    div_dn <= 1'b0;
    forever
      begin
        @(negedge clk);
        if (mul_start || div_start)
          begin
            answer_div = div_start;
            delay      = resp_delay;
            repeat (delay)
              @(posedge clk);
            if (answer_div)
              div_dn <= 1'b1;
            else
              mul_dn <= 1'b1;
            @(posedge clk);
            mul_dn <= 1'b0;
            div_dn <= 1'b0;
          end
      end
  end

initial
  begin: main_proc
    lfsr_state  = 32'h9077;
    resp_delay  = 1;
    hit_count   = 0;
    miss_count  = 0;
    dbz_count   = 0;
    ovf_count   = 0;
    rstn   <= 1'b0;
    src_a  <= '0;
    src_b  <= '0;
    op     <= mul_div_pkg::MUL;
    isword <= 1'b0;
    en     <= 1'b0;
    repeat (16)
      @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_flag("o_mul_div_ctrl_busy", busy, 1'b0);
    check_flag("o_mul_div_ctrl_done", done, 1'b0);
    check_flag("o_mul_div_ctrl_mul_start", mul_start, 1'b0);
    check_flag("o_mul_div_ctrl_div_start", div_start, 1'b0);
    check_flag("o_mul_div_ctrl_out_sel", out_sel, 1'b0);
    check_no_result();
    for (int i = 0; i < NUM_OPS; i++)
      run_operation();
    @(posedge clk);
    en <= 1'b0;
    if (hit_count == 0 || miss_count == 0 || dbz_count == 0 || ovf_count == 0)
      begin
        $display("Stimulus missed the fast, slow, divide-by-zero or overflow case");
        halt_run();
      end
    else
      begin
        $display("TESTBENCH PASSED");
        $finish;
      end
  end

endmodule

// ==== tb.f ====
+incdir+include
hw/mul_div_pkg.sv
hw/mul_div_operand_class.sv
hw/mul_div_fast_path.sv
hw/mul_div_sequencer.sv
hw/core_mul_div_ctrl.sv
sim/tb_core_mul_div_ctrl.sv
